//--- include/alu_defines.svh
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// data path width
`define ALU_WIDTH 16

`define ALU_OP_WIDTH 6

// rotate amount is kept mod 16
`define ALU_ROT_WIDTH 4

`endif

//--- logic/alu_pkg.sv
`default_nettype none

`include "alu_defines.svh"

package alu_pkg;

  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    OP_ADD = 6'b001101,
    OP_SUB = 6'b001110,
    OP_SHR = 6'b001111,
    OP_SHL = 6'b010000,
    OP_MUL = 6'b010001,
    OP_INC = 6'b010101,
    OP_DEC = 6'b010110,
    OP_AND = 6'b010111,
    OP_OR  = 6'b011000,
    OP_XOR = 6'b011001,
    OP_NOT = 6'b011010,
    OP_ROR = 6'b011011,
    OP_ROL = 6'b011100
  } alu_op_e;

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ROTATE  = 2'd1,
    CAPTURE = 2'd2
  } alu_state_e;

  typedef struct packed {
    logic [`ALU_WIDTH-1:0] first;
    logic [`ALU_WIDTH-1:0] second;
    logic [`ALU_WIDTH-1:0] base; // reference for carry and overflow
  } operand_t;

  typedef struct packed {
    logic zero;
    logic negative;
    logic carry;    // borrow on subtract
    logic overflow;
  } alu_flags_t;

endpackage

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module operand_select (
  input  alu_pkg::alu_op_e      opcode,
  input  logic [`ALU_WIDTH-1:0] acc,
  input  logic [`ALU_WIDTH-1:0] x,
  input  logic [`ALU_WIDTH-1:0] y,
  input  logic [`ALU_WIDTH-1:0] immediate,
  input  logic                  ra,
  output alu_pkg::operand_t     operands
);

  logic [`ALU_WIDTH-1:0] reg_sel;
  logic                  imm_mode;

  assign reg_sel  = ra ? y : x; // ra high picks y
  assign imm_mode = (immediate != '0);

  always_comb begin
    case (opcode)
      alu_pkg::OP_INC, alu_pkg::OP_DEC: begin
        operands.first  = reg_sel;
        operands.second = reg_sel; // sign check against the register
        operands.base   = {{(`ALU_WIDTH-1){1'b0}}, 1'b1};
      end
      alu_pkg::OP_NOT: begin
        operands.first  = reg_sel;
        operands.second = reg_sel;
        operands.base   = reg_sel;
      end
      default: begin
        if (imm_mode) begin
          operands.first  = reg_sel;
          operands.second = immediate;
          operands.base   = reg_sel;
        end else begin
          operands.first  = acc; // accumulator mode
          operands.second = reg_sel;
          operands.base   = acc;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/arith_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module arith_unit (
  input  alu_pkg::alu_op_e      opcode,
  input  alu_pkg::operand_t     operands,
  output logic [`ALU_WIDTH-1:0] result,
  output alu_pkg::alu_flags_t   flags
);

  logic [`ALU_WIDTH-1:0] a;
  logic [`ALU_WIDTH-1:0] b;
  logic [`ALU_WIDTH-1:0] base;
  logic                  add_like;
  logic                  sub_like;
  logic                  base_sign;
  logic                  b_sign;
  logic                  res_sign;

  assign a    = operands.first;
  assign b    = operands.second;
  assign base = operands.base;

  always_comb begin
    result   = '0;
    add_like = 1'b0;
    sub_like = 1'b0;
    case (opcode)
      alu_pkg::OP_ADD: begin
        result   = a + b;
        add_like = 1'b1;
      end
      alu_pkg::OP_SUB: begin
        result   = a - b;
        sub_like = 1'b1;
      end
      alu_pkg::OP_MUL: begin
        result   = a * b; // low half only
        add_like = 1'b1;
      end
      alu_pkg::OP_INC: begin
        result   = a + 1'b1;
        add_like = 1'b1;
      end
      alu_pkg::OP_DEC: begin
        result   = a - 1'b1;
        sub_like = 1'b1;
      end
      alu_pkg::OP_SHR: result = a >> b;
      alu_pkg::OP_SHL: result = a << b;
      alu_pkg::OP_AND: result = a & b;
      alu_pkg::OP_OR:  result = a | b;
      alu_pkg::OP_XOR: result = a ^ b;
      alu_pkg::OP_NOT: result = ~a;
      default:         result = '0; // rotates and unknown codes
    endcase
  end

  assign base_sign = base[`ALU_WIDTH-1];
  assign b_sign    = b[`ALU_WIDTH-1];
  assign res_sign  = result[`ALU_WIDTH-1];

  always_comb begin
    flags.overflow = (add_like && (base_sign == b_sign) && (res_sign != base_sign)) ||
                     (sub_like && (base_sign != b_sign) && (res_sign != base_sign));
    flags.carry    = (add_like && (result < base)) ||
                     (sub_like && (result > base)); // borrow
    flags.negative = res_sign;
    flags.zero     = (result == '0);
  end

endmodule

`default_nettype wire

//--- logic/rotate_counter.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module rotate_counter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic                  step,
  input  logic [`ALU_WIDTH-1:0] amount,
  output logic                  count_zero,
  output logic                  last
);

  logic [`ALU_ROT_WIDTH-1:0] count;

  // looks at the incoming amount so the FSM can skip ROTATE
  assign count_zero = (amount[`ALU_ROT_WIDTH-1:0] == '0);
  assign last       = (count == {{(`ALU_ROT_WIDTH-1){1'b0}}, 1'b1});

  always_ff @(posedge clk) begin
    if (!rst) begin
      count <= '0;
    end else if (load) begin
      count <= amount[`ALU_ROT_WIDTH-1:0]; // mod 16
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- logic/rotate_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module rotate_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic                  step,
  input  alu_pkg::alu_op_e      opcode,
  input  alu_pkg::operand_t     operands,
  output logic [`ALU_WIDTH-1:0] value
);

  logic rot_left;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rot_left <= 1'b0;
    end else if (load) begin
      rot_left <= (opcode == alu_pkg::OP_ROL);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      value <= operands.first;
    end else if (step) begin
      if (rot_left) begin
        value <= {value[`ALU_WIDTH-2:0], value[`ALU_WIDTH-1]};
      end else begin
        value <= {value[0], value[`ALU_WIDTH-1:1]}; // lsb wraps to msb
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  logic             en,
  input  alu_pkg::alu_op_e opcode,
  input  logic             count_zero,
  input  logic             last,
  output logic             load,
  output logic             step,
  output logic             capture_arith,
  output logic             capture_rot,
  output logic             busy
);

  alu_pkg::alu_state_e state;
  alu_pkg::alu_state_e state_next;
  logic                is_rot;

  assign is_rot = (opcode == alu_pkg::OP_ROR) || (opcode == alu_pkg::OP_ROL);
  assign busy   = (state != alu_pkg::IDLE);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= alu_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next    = state;
    load          = 1'b0;
    step          = 1'b0;
    capture_arith = 1'b0;
    capture_rot   = 1'b0;
    case (state)
      alu_pkg::IDLE: begin
        if (en) begin
          if (is_rot) begin
            load       = 1'b1;
            state_next = count_zero ? alu_pkg::CAPTURE : alu_pkg::ROTATE;
          end else begin
            capture_arith = 1'b1; // single cycle path
          end
        end
      end
      alu_pkg::ROTATE: begin
        step = 1'b1;
        if (last) begin
          state_next = alu_pkg::CAPTURE;
        end
      end
      alu_pkg::CAPTURE: begin
        capture_rot = 1'b1;
        state_next  = alu_pkg::IDLE;
      end
      default: state_next = alu_pkg::IDLE;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module result_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  capture_arith,
  input  logic                  capture_rot,
  input  logic [`ALU_WIDTH-1:0] arith_result,
  input  alu_pkg::alu_flags_t   arith_flags,
  input  logic [`ALU_WIDTH-1:0] rot_value,
  output logic [`ALU_WIDTH-1:0] res,
  output alu_pkg::alu_flags_t   flags,
  output logic                  done
);

  alu_pkg::alu_flags_t rot_flags;

  always_comb begin
    rot_flags.zero     = (rot_value == '0);
    rot_flags.negative = rot_value[`ALU_WIDTH-1];
    rot_flags.carry    = 1'b0; // rotates never carry
    rot_flags.overflow = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      res   <= '0;
      flags <= '0;
      done  <= 1'b0;
    end else begin
      done <= capture_arith | capture_rot;
      if (capture_arith) begin
        res   <= arith_result;
        flags <= arith_flags;
      end else if (capture_rot) begin
        res   <= rot_value;
        flags <= rot_flags;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module alu_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     en,
  input  logic [`ALU_OP_WIDTH-1:0] opcode,
  input  logic [`ALU_WIDTH-1:0]    acc,
  input  logic [`ALU_WIDTH-1:0]    x,
  input  logic [`ALU_WIDTH-1:0]    y,
  input  logic [`ALU_WIDTH-1:0]    immediate,
  input  logic                     ra,
  output logic [`ALU_WIDTH-1:0]    res,
  output alu_pkg::alu_flags_t      flags,
  output logic                     done,
  output logic                     busy
);

  alu_pkg::alu_op_e      op;
  alu_pkg::operand_t     operands;
  logic [`ALU_WIDTH-1:0] arith_result;
  alu_pkg::alu_flags_t   arith_flags;
  logic [`ALU_WIDTH-1:0] rot_value;
  logic                  load;
  logic                  step;
  logic                  capture_arith;
  logic                  capture_rot;
  logic                  count_zero;
  logic                  last;

  assign op = alu_pkg::alu_op_e'(opcode); // unknown codes pass through

  operand_select u_operand_select (
    .opcode    (op),
    .acc       (acc),
    .x         (x),
    .y         (y),
    .immediate (immediate),
    .ra        (ra),
    .operands  (operands)
  );

  arith_unit u_arith_unit (
    .opcode   (op),
    .operands (operands),
    .result   (arith_result),
    .flags    (arith_flags)
  );

  rotate_counter u_rotate_counter (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .step       (step),
    .amount     (operands.second),
    .count_zero (count_zero),
    .last       (last)
  );

  rotate_unit u_rotate_unit (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .step     (step),
    .opcode   (op),
    .operands (operands),
    .value    (rot_value)
  );

  alu_ctrl u_alu_ctrl (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .opcode        (op),
    .count_zero    (count_zero),
    .last          (last),
    .load          (load),
    .step          (step),
    .capture_arith (capture_arith),
    .capture_rot   (capture_rot),
    .busy          (busy)
  );

  result_stage u_result_stage (
    .clk           (clk),
    .rst           (rst),
    .capture_arith (capture_arith),
    .capture_rot   (capture_rot),
    .arith_result  (arith_result),
    .arith_flags   (arith_flags),
    .rot_value     (rot_value),
    .res           (res),
    .flags         (flags),
    .done          (done)
  );

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk; // 40 ns period

endmodule

`default_nettype wire

//--- tests/alu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_defines.svh"

module alu_tb;

  typedef struct packed {
    logic [`ALU_OP_WIDTH-1:0] op;
    logic [`ALU_WIDTH-1:0]    acc;
    logic [`ALU_WIDTH-1:0]    x;
    logic [`ALU_WIDTH-1:0]    y;
    logic [`ALU_WIDTH-1:0]    imm;
    logic                     ra;
    logic [`ALU_WIDTH-1:0]    exp_res;
    logic [3:0]               exp_flags; // zero, negative, carry, overflow
  } vector_t;

  localparam int N_RANDOM = 40;

  logic                     clk;
  logic                     rst;
  logic                     en;
  logic [`ALU_OP_WIDTH-1:0] opcode;
  logic [`ALU_WIDTH-1:0]    acc;
  logic [`ALU_WIDTH-1:0]    x;
  logic [`ALU_WIDTH-1:0]    y;
  logic [`ALU_WIDTH-1:0]    immediate;
  logic                     ra;
  logic [`ALU_WIDTH-1:0]    res;
  alu_pkg::alu_flags_t      flags;
  logic                     done;
  logic                     busy;
  vector_t                  vectors[$];
  vector_t                  v;
  integer                   seed;
  int                       n;
  int                       cycle_count = 0;
  int                       cycle_limit = 0;
  logic [`ALU_OP_WIDTH-1:0] op_list [14] = '{
    alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_SHR, alu_pkg::OP_SHL, alu_pkg::OP_MUL,
    alu_pkg::OP_INC, alu_pkg::OP_DEC, alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_XOR,
    alu_pkg::OP_NOT, alu_pkg::OP_ROR, alu_pkg::OP_ROL, 6'b010100
  };

  tb_clock clk_gen (.clk(clk));

  alu_top UUT (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .opcode    (opcode),
    .acc       (acc),
    .x         (x),
    .y         (y),
    .immediate (immediate),
    .ra        (ra),
    .res       (res),
    .flags     (flags),
    .done      (done),
    .busy      (busy)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("FAILED %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      fail_run($sformatf("run did not finish within %0d cycles", cycle_limit));
    end
  end

  task automatic add_vector(input logic [5:0] op, input logic [15:0] a, input logic [15:0] xv,
                            input logic [15:0] yv, input logic [15:0] im, input logic r,
                            input logic [15:0] er, input logic [3:0] ef);
    vectors.push_back({op, a, xv, yv, im, r, er, ef});
  endtask

  // op, acc, x, y, immediate, ra, res, flags
  task automatic fill_vectors();
    add_vector(alu_pkg::OP_ADD, 16'h0000, 16'h7fff, 16'h0000, 16'h0001, 0, 16'h8000, 4'b0101);
    add_vector(alu_pkg::OP_ADD, 16'hffff, 16'h0002, 16'h0000, 16'h0000, 0, 16'h0001, 4'b0010);
    add_vector(alu_pkg::OP_ADD, 16'h0010, 16'hdead, 16'h0020, 16'h0000, 1, 16'h0030, 4'b0000);
    add_vector(alu_pkg::OP_ADD, 16'h8000, 16'h0000, 16'h8000, 16'h0000, 1, 16'h0000, 4'b1011);
    add_vector(alu_pkg::OP_SUB, 16'h0000, 16'h0005, 16'h0000, 16'h0007, 0, 16'hfffe, 4'b0110);
    add_vector(alu_pkg::OP_SUB, 16'h8000, 16'h0000, 16'h0001, 16'h0000, 1, 16'h7fff, 4'b0001);
    add_vector(alu_pkg::OP_SUB, 16'h1234, 16'h1234, 16'h0000, 16'h0000, 0, 16'h0000, 4'b1000);
    add_vector(alu_pkg::OP_SUB, 16'h0000, 16'h0000, 16'h7fff, 16'hffff, 1, 16'h8000, 4'b0111);
    add_vector(alu_pkg::OP_MUL, 16'h0000, 16'h0100, 16'h0000, 16'h0100, 0, 16'h0000, 4'b1010);
    add_vector(alu_pkg::OP_MUL, 16'h4000, 16'h0002, 16'h0000, 16'h0000, 0, 16'h8000, 4'b0101);
    add_vector(alu_pkg::OP_MUL, 16'h0000, 16'h1234, 16'h0000, 16'h0000, 0, 16'h0000, 4'b1000);
    add_vector(alu_pkg::OP_INC, 16'h5555, 16'h7fff, 16'h0000, 16'h0003, 0, 16'h8000, 4'b0101);
    add_vector(alu_pkg::OP_INC, 16'h0000, 16'h0000, 16'hffff, 16'h0000, 1, 16'h0000, 4'b1010);
    add_vector(alu_pkg::OP_DEC, 16'h0000, 16'h0001, 16'h0000, 16'h0000, 0, 16'h0000, 4'b1000);
    add_vector(alu_pkg::OP_DEC, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 0, 16'hffff, 4'b0110);
    add_vector(alu_pkg::OP_DEC, 16'h0000, 16'hffff, 16'h0000, 16'h0000, 0, 16'hfffe, 4'b0111);
    add_vector(alu_pkg::OP_SHR, 16'h0000, 16'h8010, 16'h0000, 16'h0004, 0, 16'h0801, 4'b0000);
    add_vector(alu_pkg::OP_SHL, 16'h00f1, 16'h0008, 16'h0000, 16'h0000, 0, 16'hf100, 4'b0100);
    add_vector(alu_pkg::OP_SHL, 16'h0000, 16'h0001, 16'h0000, 16'h0010, 0, 16'h0000, 4'b1000);
    add_vector(alu_pkg::OP_AND, 16'h0000, 16'hf0f0, 16'h0000, 16'hff00, 0, 16'hf000, 4'b0100);
    add_vector(alu_pkg::OP_OR, 16'h1200, 16'h0000, 16'h0034, 16'h0000, 1, 16'h1234, 4'b0000);
    add_vector(alu_pkg::OP_XOR, 16'h0000, 16'hffff, 16'h0000, 16'haaaa, 0, 16'h5555, 4'b0000);
    add_vector(alu_pkg::OP_NOT, 16'h1234, 16'h0000, 16'h0000, 16'h0000, 0, 16'hffff, 4'b0100);
    add_vector(alu_pkg::OP_NOT, 16'h0000, 16'h0000, 16'hffff, 16'h0f0f, 1, 16'h0000, 4'b1000);
    add_vector(alu_pkg::OP_ROR, 16'h8001, 16'h0000, 16'h0000, 16'h0000, 0, 16'h8001, 4'b0100);
    add_vector(alu_pkg::OP_ROR, 16'h0000, 16'h8001, 16'h0000, 16'h0001, 0, 16'hc000, 4'b0100);
    add_vector(alu_pkg::OP_ROR, 16'h0000, 16'h8001, 16'h0000, 16'h000f, 0, 16'h0003, 4'b0000);
    add_vector(alu_pkg::OP_ROR, 16'h8001, 16'h0000, 16'h0011, 16'h0000, 1, 16'hc000, 4'b0100);
    add_vector(alu_pkg::OP_ROL, 16'h1234, 16'h0000, 16'h0000, 16'h0000, 0, 16'h1234, 4'b0000);
    add_vector(alu_pkg::OP_ROL, 16'h0000, 16'h8001, 16'h0000, 16'h0001, 0, 16'h0003, 4'b0000);
    add_vector(alu_pkg::OP_ROL, 16'h0000, 16'h0000, 16'h8001, 16'h000f, 1, 16'hc000, 4'b0100);
    add_vector(alu_pkg::OP_ROL, 16'h0000, 16'h1234, 16'h0000, 16'h0011, 0, 16'h2468, 4'b0000);
    add_vector(6'b010100, 16'h0000, 16'h0005, 16'h0000, 16'h0003, 0, 16'h0000, 4'b1000);
    add_vector(6'b111111, 16'hffff, 16'hffff, 16'h0000, 16'h0000, 0, 16'h0000, 4'b1000);
  endtask

  function automatic int latency(vector_t s);
    logic [15:0] amount;
    amount = (s.imm != '0) ? s.imm : (s.ra ? s.y : s.x);
    if (s.op == alu_pkg::OP_ROR || s.op == alu_pkg::OP_ROL) begin
      return (amount % 16) + 1; // edges after acceptance
    end
    return 0;
  endfunction

  function automatic vector_t predict(vector_t s);
    logic [15:0] r_val;
    logic [15:0] first;
    logic [15:0] second;
    logic [15:0] base;
    logic [15:0] r;
    logic        ov;
    logic        c;
    int          i;
    vector_t     o;
    o = s;
    r_val = s.ra ? s.y : s.x;
    first = (s.imm != '0) ? r_val : s.acc;
    second = (s.imm != '0) ? s.imm : r_val;
    if (s.op == alu_pkg::OP_INC || s.op == alu_pkg::OP_DEC || s.op == alu_pkg::OP_NOT) begin
      first = r_val;
      second = r_val;
    end
    base = (s.op == alu_pkg::OP_INC || s.op == alu_pkg::OP_DEC) ? 16'h0001 : first;
    case (s.op)
      alu_pkg::OP_ADD: r = first + second;
      alu_pkg::OP_SUB: r = first - second;
      alu_pkg::OP_MUL: r = first * second;
      alu_pkg::OP_INC: r = first + 16'h0001;
      alu_pkg::OP_DEC: r = first - 16'h0001;
      alu_pkg::OP_SHR: r = first >> second;
      alu_pkg::OP_SHL: r = first << second;
      alu_pkg::OP_AND: r = first & second;
      alu_pkg::OP_OR:  r = first | second;
      alu_pkg::OP_XOR: r = first ^ second;
      alu_pkg::OP_NOT: r = ~first;
      alu_pkg::OP_ROR, alu_pkg::OP_ROL: begin
        r = first;
        for (i = 0; i < second % 16; i++) begin
          r = (s.op == alu_pkg::OP_ROL) ? {r[14:0], r[15]} : {r[0], r[15:1]};
        end
      end
      default: r = '0;
    endcase
    ov = 1'b0;
    c = 1'b0;
    if (s.op == alu_pkg::OP_ADD || s.op == alu_pkg::OP_MUL || s.op == alu_pkg::OP_INC) begin
      ov = (base[15] == second[15]) && (r[15] != base[15]);
      c = (r < base);
    end else if (s.op == alu_pkg::OP_SUB || s.op == alu_pkg::OP_DEC) begin
      ov = (base[15] != second[15]) && (r[15] != base[15]);
      c = (r > base); // borrow
    end
    o.exp_res = r;
    o.exp_flags = {r == '0, r[15], c, ov};
    return o;
  endfunction

  task automatic check_idle(input string tag);
    check_value({"done ", tag}, {15'h0, done}, 16'h0000);
    check_value({"busy ", tag}, {15'h0, busy}, 16'h0000);
    check_value({"res ", tag}, res, 16'h0000);
    check_value({"flags ", tag}, {12'h0, flags}, 16'h0000);
  endtask

  task automatic run_vector(input vector_t s, input int idx);
    int edges;
    opcode = s.op;
    acc = s.acc;
    x = s.x;
    y = s.y;
    immediate = s.imm;
    ra = s.ra;
    en = 1'b1;
    @(posedge clk);
    #2;
    en = 1'b0;
    edges = 0;
    while (done !== 1'b1) begin
      check_value($sformatf("busy[%0d]", idx), {15'h0, busy}, 16'h0001);
      @(posedge clk);
      #2;
      edges++;
    end
    check_value($sformatf("latency[%0d]", idx), 16'(edges), 16'(latency(s)));
    check_value($sformatf("res[%0d]", idx), res, s.exp_res);
    check_value($sformatf("flags[%0d]", idx), {12'h0, flags}, {12'h0, s.exp_flags});
    @(posedge clk);
    #2;
    check_value($sformatf("done pulse[%0d]", idx), {15'h0, done}, 16'h0000);
    check_value($sformatf("res held[%0d]", idx), res, s.exp_res);
  endtask

  initial begin
    seed = 32'h1ac6;
    rst = 1'b0;
    en = 1'b0;
    opcode = '0;
    acc = '0;
    x = '0;
    y = '0;
    immediate = '0;
    ra = 1'b0;
    fill_vectors();
    cycle_limit = (vectors.size() + N_RANDOM + 2) * 20 + 100;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b1;
    check_idle("after reset");
    foreach (vectors[i]) begin
      run_vector(vectors[i], i);
    end
    for (n = 0; n < N_RANDOM; n++) begin
      v.op = op_list[$unsigned($random(seed)) % 14];
      v.acc = 16'($random(seed));
      v.x = 16'($random(seed));
      v.y = 16'($random(seed));
      v.imm = ($random(seed) % 2 == 0) ? 16'h0000 : 16'($random(seed));
      v.ra = 1'($random(seed));
      run_vector(predict(v), vectors.size() + n);
    end
    // en during a rotate must be dropped
    opcode = alu_pkg::OP_ROR;
    x = 16'h4001;
    immediate = 16'h000f;
    ra = 1'b0;
    en = 1'b1;
    @(posedge clk);
    #2;
    en = 1'b0;
    @(posedge clk);
    #2;
    check_value("busy while rotating", {15'h0, busy}, 16'h0001);
    opcode = alu_pkg::OP_ADD;
    x = 16'h0001;
    immediate = 16'h0001;
    en = 1'b1;
    @(posedge clk);
    #2;
    en = 1'b0;
    while (done !== 1'b1) begin
      @(posedge clk);
      #2;
    end
    check_value("res after ignored en", res, 16'h8002);
    check_value("flags after ignored en", {12'h0, flags}, 16'h0004);
    repeat (3) begin
      @(posedge clk);
      #2;
      check_value("done after ignored en", {15'h0, done}, 16'h0000);
    end
    // reset in the middle of a rotate
    opcode = alu_pkg::OP_ROL;
    x = 16'h8001;
    immediate = 16'h000f;
    en = 1'b1;
    @(posedge clk);
    #2;
    en = 1'b0;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b1;
    check_idle("after mid-rotate reset");
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
logic/alu_pkg.sv
logic/operand_select.sv
logic/arith_unit.sv
logic/rotate_counter.sv
logic/rotate_unit.sv
logic/alu_ctrl.sv
logic/result_stage.sv
logic/alu_top.sv
tests/tb_clock.sv
tests/alu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module alu_tb -f build.f -o alu_sim
./obj_dir/alu_sim | tee sim.log
if grep -q "^Testbench passed$" sim.log; then
  echo "simulation ok"
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
